// ==== rtl/sdram_arbiter.sv ====
// Fixed-priority arbiter for the SDRAM slot
// Holds peer strobes pending; order is download, cpu, gfx, refresh

`timescale 1ns/1ns

module sdram_arbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         downloading,
    input  logic                         prog_we,
    input  logic [sdram_pkg::ADDR_W-1:0] prog_addr,
    input  logic [7:0]                   prog_data,
    input  logic [1:0]                   prog_mask,
    input  logic                         cpu_req,
    input  logic                         gfx_req,
    input  logic [sdram_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [sdram_pkg::ADDR_W-1:0] gfx_addr,
    input  logic                         autorefresh,
    input  logic                         slot_free,
    output logic                         req,
    output sdram_pkg::sdram_req_t        req_info
);
    import sdram_pkg::*;

    logic              prog_p, cpu_p, gfx_p, ref_p;   // Pending bits
    logic [ADDR_W-1:0] prog_addr_q, cpu_addr_q, gfx_addr_q;
    logic [7:0]        prog_data_q;
    logic [1:0]        prog_mask_q;
    logic              grant;
    logic              take_prog, take_cpu, take_gfx, take_ref;

    assign req       = prog_p | cpu_p | gfx_p | ref_p;
    assign grant     = req & slot_free;
    assign take_prog = grant & prog_p;
    assign take_cpu  = grant & ~prog_p & cpu_p;
    assign take_gfx  = grant & ~prog_p & ~cpu_p & gfx_p;
    assign take_ref  = grant & ~prog_p & ~cpu_p & ~gfx_p;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prog_p <= 1'b0;
            cpu_p  <= 1'b0;
            gfx_p  <= 1'b0;
            ref_p  <= 1'b0;
        end else begin
            // A strobe in the grant cycle is a new request, so set wins
            if (downloading && prog_we) prog_p <= 1'b1;
            else if (take_prog)         prog_p <= 1'b0;
            if (!downloading && cpu_req) cpu_p <= 1'b1;
            else if (take_cpu)           cpu_p <= 1'b0;
            if (!downloading && gfx_req) gfx_p <= 1'b1;
            else if (take_gfx)           gfx_p <= 1'b0;
            if (autorefresh)    ref_p <= 1'b1;
            else if (take_ref)  ref_p <= 1'b0;
        end
    end

    // Captured request payload
    always_ff @(posedge clk) begin
        if (downloading && prog_we) begin
            prog_addr_q <= prog_addr;
            prog_data_q <= prog_data;
            prog_mask_q <= prog_mask;
        end
        if (!downloading && cpu_req) cpu_addr_q <= cpu_addr;
        if (!downloading && gfx_req) gfx_addr_q <= gfx_addr;
    end

    always_comb begin
        req_info.wdata = prog_data_q;
        req_info.mask  = prog_mask_q;
        req_info.port  = PORT_CPU;
        if (prog_p) begin
            req_info.kind = REQ_WRITE;
            req_info.addr = prog_addr_q;
        end else if (cpu_p) begin
            req_info.kind = REQ_READ;
            req_info.addr = cpu_addr_q;
        end else if (gfx_p) begin
            req_info.kind = REQ_READ;
            req_info.port = PORT_GFX;
            req_info.addr = gfx_addr_q;
        end else begin
            req_info.kind = REQ_REFRESH;     // Also idle default
            req_info.addr = '0;
        end
    end

endmodule

// ==== rtl/sdram_ctrl.sv ====
// SDRAM slot sequencer
// Runs eight-cycle access slots: activate, read or write with auto
// precharge, data capture and ack. Also inserts mode reloads.

`timescale 1ns/1ns

module sdram_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   init_done,
    input  logic                   downloading,
    input  logic                   req,
    input  sdram_pkg::sdram_req_t  req_info,
    output logic                   slot_free,
    output sdram_pkg::sdram_pins_t pins,
    output logic                   dq_oe,
    output logic [15:0]            dq_out,
    input  logic [15:0]            dq_in,
    output logic                   cpu_ack,
    output logic                   gfx_ack,
    output logic [31:0]            rd_data
);
    import sdram_pkg::*;

    localparam logic [2:0] LAST = 3'(SLOT_LEN - 1);

    logic        busy;
    logic [2:0]  cnt;          // Slot cycle shown on the pins
    logic        is_mode;      // Current slot is a mode reload
    logic        mode_pend;
    logic        dl_q;
    logic        slot_open;
    logic        grant;
    logic        start_mode;
    logic        rd_slot;
    logic        wr_slot;
    sdram_req_t  cur;
    sdram_pins_t pins_q;
    logic [15:0] dq_out_q;

    assign slot_open  = ~busy | (cnt == LAST);
    assign slot_free  = init_done & ~mode_pend & slot_open;
    assign start_mode = init_done & mode_pend & slot_open;
    assign grant      = req & slot_free;
    assign rd_slot    = ~is_mode & (cur.kind == REQ_READ);
    assign wr_slot    = ~is_mode & (cur.kind == REQ_WRITE);

    assign pins   = pins_q;
    assign dq_oe  = pins_q.we;
    assign dq_out = dq_out_q;

    // Any change of downloading needs a new burst length
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dl_q      <= 1'b0;
            mode_pend <= 1'b0;
        end else begin
            dl_q <= downloading;
            if (dl_q != downloading) mode_pend <= 1'b1;
            else if (start_mode)     mode_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            is_mode <= 1'b0;
            cpu_ack <= 1'b0;
            gfx_ack <= 1'b0;
            pins_q  <= '{cmd: NOP, a: '0, dqm: 2'b00, we: 1'b0};
        end else begin
            pins_q.cmd <= NOP;
            pins_q.we  <= 1'b0;                    // DQ for one cycle only
            cpu_ack    <= 1'b0;
            gfx_ack    <= 1'b0;
            if (start_mode) begin
                busy          <= 1'b1;
                is_mode       <= 1'b1;
                cnt           <= 3'(SLOT_LEN - 4);     // Short slot
                pins_q.cmd    <= LOAD_MODE;
                pins_q.a.word <= mode_word(~downloading);  // BL1 while loading
            end else if (grant) begin
                busy          <= 1'b1;
                is_mode       <= 1'b0;
                cnt           <= '0;
                pins_q.cmd    <= (req_info.kind == REQ_REFRESH) ? AUTOREFRESH : ACTIVATE;
                pins_q.a.word <= req_info.addr[ADDR_W-1 -: ROW_W];   // Row
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST) busy <= 1'b0;
                case (cnt)
                    3'd1: begin
                        if (rd_slot || wr_slot) begin
                            pins_q.cmd   <= wr_slot ? WRITE : READ;
                            pins_q.a.col <= '{rsvd_hi: 2'b00, ap: 1'b1, rsvd_lo: 1'b0,
                                              col: cur.addr[COL_W-1:0]};
                            pins_q.we    <= wr_slot;
                            pins_q.dqm   <= wr_slot ? cur.mask : 2'b00;
                        end
                    end
                    3'd6: begin
                        if (rd_slot) begin                 // Ack lands in last cycle
                            cpu_ack <= (cur.port == PORT_CPU);
                            gfx_ack <= (cur.port == PORT_GFX);
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Slot payload and read data
    always_ff @(posedge clk) begin
        if (grant) cur <= req_info;
        if (busy && cnt == 3'd1) dq_out_q <= {cur.wdata, cur.wdata};  // Byte on both halves
        if (busy && rd_slot) begin
            if (cnt == 3'd4) rd_data[15:0]  <= dq_in;   // First word, CL2 after READ
            if (cnt == 3'd5) rd_data[31:16] <= dq_in;
        end
    end

endmodule

// ==== rtl/sdram_init.sv ====
// SDRAM power-up sequencer
// Waits with NOP, then precharge all, refresh, load mode, precharge all

`timescale 1ns/1ns

module sdram_init (
    input  logic                  clk,
    input  logic                  rst,
    output sdram_pkg::sdram_pins_t pins,
    output logic                  init_done
);
    import sdram_pkg::*;

    typedef enum logic [2:0] {
        S_WAIT, S_PRE1, S_REF, S_MODE, S_PRE2, S_DONE
    } init_state_e;

    init_state_e       state;
    logic [WAIT_W-1:0] wait_cnt;
    sdram_pins_t       pins_q;

    assign pins = pins_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_WAIT;
            wait_cnt  <= WAIT_W'(INIT_WAIT - 1);
            init_done <= 1'b0;
            pins_q    <= '{cmd: NOP, a: '0, dqm: 2'b11, we: 1'b0};
        end else begin
            pins_q.cmd <= NOP;                       // One-cycle commands
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                case (state)
                    S_WAIT: begin
                        pins_q.cmd      <= PRECHARGE;
                        pins_q.a.word   <= '0;
                        pins_q.a.col.ap <= 1'b1;     // All banks
                        wait_cnt        <= WAIT_W'(T_RP - 1);
                        state           <= S_PRE1;
                    end
                    S_PRE1: begin
                        pins_q.cmd <= AUTOREFRESH;
                        wait_cnt   <= WAIT_W'(T_RFC - 1);
                        state      <= S_REF;
                    end
                    S_REF: begin
                        pins_q.cmd    <= LOAD_MODE;
                        pins_q.a.word <= mode_word(1'b1);  // Burst 2, CL2
                        wait_cnt      <= WAIT_W'(T_MRD - 1);
                        state         <= S_MODE;
                    end
                    S_MODE: begin
                        pins_q.cmd      <= PRECHARGE;
                        pins_q.a.word   <= '0;
                        pins_q.a.col.ap <= 1'b1;
                        wait_cnt        <= WAIT_W'(T_RP - 1);
                        state           <= S_PRE2;
                    end
                    S_PRE2: begin
                        init_done <= 1'b1;           // Hand over to sequencer
                        state     <= S_DONE;
                    end
                    default: begin
                        state <= S_DONE;             // Hold here
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/sdram_pkg.sv ====
// SDRAM controller shared definitions
// Command codes, timing constants, request and pin bundles

package sdram_pkg;

    // {ncs, nras, ncas, nwe}
    typedef enum logic [3:0] {
        LOAD_MODE   = 4'b0000,
        AUTOREFRESH = 4'b0001,
        PRECHARGE   = 4'b0010,
        ACTIVATE    = 4'b0011,
        WRITE       = 4'b0100,
        READ        = 4'b0101,
        NOP         = 4'b0111,
        INHIBIT     = 4'b1000
    } sdram_cmd_e;

    localparam int ADDR_W    = 22;    // Request word address
    localparam int ROW_W     = 13;
    localparam int COL_W     = 9;
    localparam int INIT_WAIT = 9750;  // About 100 us of NOP
    localparam int WAIT_W    = $clog2(INIT_WAIT);
    localparam int T_RP      = 2;
    localparam int T_RFC     = 11;
    localparam int T_MRD     = 3;
    localparam int SLOT_LEN  = 8;
    localparam int CAS_LAT   = 2;

    typedef enum logic [1:0] {REQ_READ, REQ_WRITE, REQ_REFRESH} sdram_kind_e;
    typedef enum logic {PORT_CPU, PORT_GFX} sdram_port_e;

    typedef struct packed {
        sdram_kind_e       kind;
        sdram_port_e       port;   // Read owner
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;  // Download byte
        logic [1:0]        mask;   // {dqmh, dqml}, 1 masks
    } sdram_req_t;

    // Column view of the A bus for READ, WRITE and PRECHARGE
    typedef struct packed {
        logic [1:0]       rsvd_hi;
        logic             ap;       // Auto precharge / all banks
        logic             rsvd_lo;
        logic [COL_W-1:0] col;
    } sdram_col_t;

    typedef union packed {
        logic [ROW_W-1:0] word;     // Row or mode register
        sdram_col_t       col;
    } sdram_a_u;

    typedef struct packed {
        sdram_cmd_e cmd;
        sdram_a_u   a;
        logic [1:0] dqm;            // {dqmh, dqml}
        logic       we;             // Drive DQ this cycle
    } sdram_pins_t;

    // Mode register: single writes, sequential, burst 1 or 2
    function automatic logic [ROW_W-1:0] mode_word(input logic burst2);
        mode_word = {3'b000, 1'b1, 2'b00, 3'(CAS_LAT), 1'b0, 2'b00, burst2};
    endfunction

endpackage

// ==== rtl/sdram_top.sv ====
// SDRAM controller top level
// Init sequencer owns the pins until init_done, then the slot sequencer

`timescale 1ns/1ns

module sdram_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         downloading,
    input  logic                         prog_we,
    input  logic [sdram_pkg::ADDR_W-1:0] prog_addr,
    input  logic [7:0]                   prog_data,
    input  logic [1:0]                   prog_mask,
    input  logic                         cpu_req,
    input  logic [sdram_pkg::ADDR_W-1:0] cpu_addr,
    output logic                         cpu_ack,
    output logic [31:0]                  cpu_data,
    input  logic                         gfx_req,
    input  logic [sdram_pkg::ADDR_W-1:0] gfx_addr,
    output logic                         gfx_ack,
    output logic [31:0]                  gfx_data,
    input  logic                         autorefresh,
    output logic                         init_done,
    inout  wire  [15:0]                  sdram_dq,
    output logic [12:0]                  sdram_a,
    output logic [1:0]                   sdram_ba,
    output logic                         sdram_dqml,
    output logic                         sdram_dqmh,
    output logic                         sdram_ncs,
    output logic                         sdram_nras,
    output logic                         sdram_ncas,
    output logic                         sdram_nwe,
    output logic                         sdram_cke
);
    import sdram_pkg::*;

    sdram_pins_t init_pins, ctrl_pins, pins_mux;
    sdram_req_t  req_info;
    logic        arb_req, slot_free;
    logic        dq_oe;
    logic [15:0] dq_out;
    logic [31:0] rd_data;

    sdram_init u_init (
        .clk(clk), .rst(rst), .pins(init_pins), .init_done(init_done)
    );

    sdram_arbiter u_arb (
        .clk(clk), .rst(rst), .downloading(downloading),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .cpu_req(cpu_req), .gfx_req(gfx_req),
        .cpu_addr(cpu_addr), .gfx_addr(gfx_addr), .autorefresh(autorefresh),
        .slot_free(slot_free), .req(arb_req), .req_info(req_info)
    );

    sdram_ctrl u_ctrl (
        .clk(clk), .rst(rst), .init_done(init_done), .downloading(downloading),
        .req(arb_req), .req_info(req_info), .slot_free(slot_free),
        .pins(ctrl_pins), .dq_oe(dq_oe), .dq_out(dq_out), .dq_in(sdram_dq),
        .cpu_ack(cpu_ack), .gfx_ack(gfx_ack), .rd_data(rd_data)
    );

    assign pins_mux = init_done ? ctrl_pins : init_pins;   // Pin ownership

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = pins_mux.cmd;
    assign sdram_a                  = pins_mux.a.word;
    assign {sdram_dqmh, sdram_dqml} = pins_mux.dqm;
    assign sdram_dq   = (pins_mux.we && dq_oe) ? dq_out : 16'hzzzz;
    assign sdram_ba   = 2'b00;       // Single bank in use
    assign sdram_cke  = 1'b1;
    assign cpu_data   = rd_data;     // Valid with the ack
    assign gfx_data   = rd_data;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_sdram -o tb_sdram

# Assertion errors must not stop the run before the summary line
./obj_dir/tb_sdram +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

// ==== sim.f ====
rtl/sdram_pkg.sv
rtl/sdram_init.sv
rtl/sdram_arbiter.sv
rtl/sdram_ctrl.sv
rtl/sdram_top.sv
verif/sdram_model.sv
verif/sdram_assertions.sv
verif/tb_sdram.sv

// ==== verif/sdram_assertions.sv ====
// Protocol assertions for the SDRAM slot sequencer
// Bound into every sdram_ctrl instance

`timescale 1ns/1ns

module sdram_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   init_done,
    input sdram_pkg::sdram_pins_t pins,
    input logic                   dq_oe,
    input logic                   cpu_ack,
    input logic                   gfx_ack
);
    import sdram_pkg::*;

    int fail_cnt = 0;   // Read by the testbench summary

    a_no_act_early: assert property (@(posedge clk) disable iff (rst)
        !init_done |-> pins.cmd != ACTIVATE)
        else begin fail_cnt++; $error("ACTIVATE before init done"); end

    a_rw_after_act: assert property (@(posedge clk) disable iff (rst)
        pins.cmd == ACTIVATE |-> ##2 (pins.cmd == READ || pins.cmd == WRITE))
        else begin fail_cnt++; $error("No READ or WRITE two cycles after ACTIVATE"); end

    a_dq_in_write: assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> pins.cmd == WRITE)
        else begin fail_cnt++; $error("DQ driven outside a WRITE cycle"); end

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        (cpu_ack || gfx_ack) |=> !(cpu_ack || gfx_ack))
        else begin fail_cnt++; $error("Ack longer than one cycle"); end

    // READ sits in slot cycle 2, the ack in cycle 7
    a_ack_after_read: assert property (@(posedge clk) disable iff (rst)
        pins.cmd == READ |-> ##5 (cpu_ack || gfx_ack))
        else begin fail_cnt++; $error("No ack five cycles after READ"); end

endmodule

bind sdram_ctrl sdram_assertions u_assert (.*);

// ==== verif/sdram_model.sv ====
// Behavioral SDRAM model, 16-bit, single bank
// CAS latency 2, read burst 1 or 2 from the mode register, byte masks

`timescale 1ns/1ns

module sdram_model (
    input  logic        clk,
    inout  wire  [15:0] dq,
    input  logic [12:0] a,
    input  logic [1:0]  ba,
    input  logic        dqml,
    input  logic        dqmh,
    input  logic        ncs,
    input  logic        nras,
    input  logic        ncas,
    input  logic        nwe,
    input  logic        cke
);
    import sdram_pkg::*;

    logic [15:0] mem [int unsigned];   // Sparse word store
    logic [12:0] row;
    logic        burst2;
    logic [1:0]  rd_step;              // Read output pipeline
    logic [21:0] rd_addr;
    logic        dq_en;
    logic [15:0] dq_val;
    logic [3:0]  cmd;

    assign cmd = {ncs, nras, ncas, nwe};
    assign dq  = dq_en ? dq_val : 16'hzzzz;

    // Unwritten words read back a pattern of their address
    function automatic logic [15:0] fill_word(input logic [21:0] addr);
        return addr[15:0] ^ {addr[21:16], addr[21:12]};
    endfunction

    function automatic logic [15:0] read_word(input logic [21:0] addr);
        if (mem.exists(addr)) return mem[addr];
        return fill_word(addr);
    endfunction

    initial begin
        row     = '0;
        burst2  = 1'b1;
        rd_step = '0;
        rd_addr = '0;
        dq_en   = 1'b0;
        dq_val  = '0;
    end

    always @(posedge clk) begin
        logic [15:0] w;
        case (rd_step)
            2'd1: begin                              // CL2 first word
                dq_en   <= 1'b1;
                dq_val  <= read_word(rd_addr);
                rd_step <= burst2 ? 2'd2 : 2'd3;
            end
            2'd2: begin                              // Sequential wrap in pair
                dq_val  <= read_word({rd_addr[21:1], ~rd_addr[0]});
                rd_step <= 2'd3;
            end
            2'd3: begin
                dq_en   <= 1'b0;
                rd_step <= 2'd0;
            end
            default: begin
            end
        endcase
        if (cke && ba == 2'b00) begin                // Only bank 0 is modelled
            case (cmd)
                LOAD_MODE: burst2 <= (a[2:0] == 3'b001);
                ACTIVATE:  row    <= a;
                READ: begin
                    rd_addr <= {row, a[8:0]};
                    rd_step <= 2'd1;
                end
                WRITE: begin
                    w = read_word({row, a[8:0]});
                    if (!dqml) w[7:0] = dq[7:0];
                    if (!dqmh) w[15:8] = dq[15:8];
                    mem[{row, a[8:0]}] = w;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== verif/tb_sdram.sv ====
// Testbench for the SDRAM controller
// Download writes, cpu and gfx reads, refresh and mode reload checks

`timescale 1ns/1ns

module tb_sdram;
    import sdram_pkg::*;

    localparam int T_CLK   = 8;
    localparam int N_PAIRS = 10;                  // Word pairs downloaded
    localparam int N_TESTS = 4 * N_PAIRS + 10;

    logic              clk, rst, downloading, prog_we, cpu_req, gfx_req, autorefresh;
    logic [ADDR_W-1:0] prog_addr, cpu_addr, gfx_addr;
    logic [7:0]        prog_data;
    logic [1:0]        prog_mask;
    logic              cpu_ack, gfx_ack, init_done;
    logic [31:0]       cpu_data, gfx_data;
    wire  [15:0]       sdram_dq;
    logic [12:0]       sdram_a;
    logic [1:0]        sdram_ba;
    logic              sdram_dqml, sdram_dqmh, sdram_ncs, sdram_nras, sdram_ncas;
    logic              sdram_nwe, sdram_cke;

    int          errors = 0;
    int          nop_cnt = 0, wr_cnt = 0, ref_cnt = 0, mode_cnt = 0;
    int          cycle = 0, cpu_acks = 0, gfx_acks = 0, cpu_cyc = 0, gfx_cyc = 0;
    logic [31:0] cpu_last, gfx_last;
    logic        started = 0, dl_prev = 0, mode_need = 0;
    sdram_cmd_e  cmd;
    sdram_cmd_e  init_seq[$];
    logic [15:0] shadow [int unsigned];            // Expected SDRAM words
    logic [ADDR_W-1:0] bases[N_PAIRS];
    logic [31:0] lfsr = 32'h5f09b817;

    sdram_top u_dut (.*);

    sdram_model u_mem (
        .clk(clk), .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba), .dqml(sdram_dqml),
        .dqmh(sdram_dqmh), .ncs(sdram_ncs), .nras(sdram_nras), .ncas(sdram_ncas),
        .nwe(sdram_nwe), .cke(sdram_cke)
    );

    assign cmd = sdram_cmd_e'({sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe});

    initial begin
        clk = 1'b0;
        forever #(T_CLK / 2) clk = ~clk;
    end

    initial begin
        #((INIT_WAIT + 64 * SLOT_LEN * N_TESTS) * T_CLK);
        $display("Timeout: the test sequence did not complete");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [15:0] expected_word(input logic [21:0] addr);
        if (shadow.exists(addr)) return shadow[addr];
        return addr[15:0] ^ {addr[21:16], addr[21:12]};   // Model fill rule
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, got);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Error at t=%0t: %s", $time, what);
        end
    endtask

    // Samples mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            cycle++;
            if (!init_done && cmd != NOP) begin
                if (!started) check_true(nop_cnt >= INIT_WAIT, "init wait too short");
                started = 1'b1;
                init_seq.push_back(cmd);
            end else if (!init_done) begin
                nop_cnt++;
            end
            if (downloading != dl_prev) mode_need = 1'b1;
            dl_prev = downloading;
            if (init_done && cmd == ACTIVATE) check_true(!mode_need, "access before LOAD_MODE");
            if (cmd == LOAD_MODE) begin
                check_val("mode burst", {31'd0, !downloading}, {29'd0, sdram_a[2:0]});
                check_val("mode cas", CAS_LAT, {29'd0, sdram_a[6:4]});
                mode_need = 1'b0;
                mode_cnt++;
            end
            if (cmd == WRITE) wr_cnt++;
            if (init_done && cmd == AUTOREFRESH) ref_cnt++;
            if (cpu_ack) begin
                cpu_acks++;
                cpu_cyc  = cycle;
                cpu_last = cpu_data;
            end
            if (gfx_ack) begin
                gfx_acks++;
                gfx_cyc  = cycle;
                gfx_last = gfx_data;
            end
            check_true(!(downloading && (cpu_ack || gfx_ack)), "ack while downloading");
        end
    end

    task automatic wait_mode();
        int n0;
        n0 = mode_cnt;
        while (mode_cnt == n0) @(posedge clk);
    endtask

    task automatic prog_write(input logic [ADDR_W-1:0] addr);
        logic [31:0] r;
        logic [15:0] w;
        int          n0;
        take_bits(10, r);
        n0 = wr_cnt;
        prog_addr <= addr;
        prog_data <= r[7:0];
        prog_mask <= r[9:8];
        prog_we   <= 1'b1;
        @(posedge clk);
        prog_we <= 1'b0;
        w = expected_word(addr);
        if (!r[8]) w[7:0] = r[7:0];
        if (!r[9]) w[15:8] = r[7:0];
        shadow[addr] = w;
        while (wr_cnt == n0) @(posedge clk);
    endtask

    task automatic read_both(input logic [ADDR_W-1:0] ca, ga, input logic use_cpu, use_gfx);
        int c0, g0;
        c0 = cpu_acks;
        g0 = gfx_acks;
        cpu_addr <= ca;
        gfx_addr <= ga;
        cpu_req  <= use_cpu;
        gfx_req  <= use_gfx;
        @(posedge clk);
        cpu_req <= 1'b0;
        gfx_req <= 1'b0;
        while ((use_cpu && cpu_acks == c0) || (use_gfx && gfx_acks == g0)) @(posedge clk);
        repeat (SLOT_LEN) @(posedge clk);          // Catch any extra ack
        if (use_cpu) begin
            check_val("cpu_ack count", c0 + 1, cpu_acks);
            check_val("cpu_data", {expected_word(ca + 1), expected_word(ca)}, cpu_last);
        end
        if (use_gfx) begin
            check_val("gfx_ack count", g0 + 1, gfx_acks);
            check_val("gfx_data", {expected_word(ga + 1), expected_word(ga)}, gfx_last);
        end
        if (use_cpu && use_gfx) check_true(cpu_cyc < gfx_cyc, "gfx acked before cpu");
    endtask

    initial begin
        logic [31:0] r;
        int          a0;
        rst = 1'b1;
        {downloading, prog_we, cpu_req, gfx_req, autorefresh} = '0;
        {prog_addr, cpu_addr, gfx_addr, prog_data, prog_mask} = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (!init_done) @(posedge clk);
        check_val("init_seq size", 4, init_seq.size());
        if (init_seq.size() == 4) begin
            check_val("init cmd 0", PRECHARGE, init_seq[0]);
            check_val("init cmd 1", AUTOREFRESH, init_seq[1]);
            check_val("init cmd 2", LOAD_MODE, init_seq[2]);
            check_val("init cmd 3", PRECHARGE, init_seq[3]);
        end
        downloading <= 1'b1;
        wait_mode();
        a0 = cpu_acks + gfx_acks;
        cpu_req <= 1'b1;                             // Must be dropped
        gfx_req <= 1'b1;
        @(posedge clk);
        cpu_req <= 1'b0;
        gfx_req <= 1'b0;
        repeat (3 * SLOT_LEN) @(posedge clk);
        check_val("acks in download", a0, cpu_acks + gfx_acks);
        for (int i = 0; i < N_PAIRS; i++) begin
            take_bits(ADDR_W - 1, r);
            bases[i] = {r[ADDR_W-2:0], 1'b0};        // Even word address
            prog_write(bases[i]);
            prog_write(bases[i] + 1);
        end
        downloading <= 1'b0;                         // First read races the reload
        for (int i = 0; i < N_PAIRS; i++) begin
            read_both(bases[i], '0, 1'b1, 1'b0);
            read_both('0, bases[N_PAIRS-1-i], 1'b0, 1'b1);
        end
        for (int i = 0; i + 1 < N_PAIRS; i += 2) read_both(bases[i], bases[i+1], 1'b1, 1'b1);
        a0 = ref_cnt;
        autorefresh <= 1'b1;
        @(posedge clk);
        autorefresh <= 1'b0;
        r = cpu_acks + gfx_acks;
        while (ref_cnt == a0) @(posedge clk);
        repeat (2 * SLOT_LEN) @(posedge clk);
        check_val("acks after refresh", r, cpu_acks + gfx_acks);
        downloading <= 1'b1;                         // One more reload each way
        wait_mode();
        downloading <= 1'b0;
        wait_mode();
        repeat (SLOT_LEN) @(posedge clk);
        r = errors + u_dut.u_ctrl.u_assert.fail_cnt;
        $display("Errors: %0d checks, %0d assertions, %0d total",
                 errors, u_dut.u_ctrl.u_assert.fail_cnt, r);
        if (r == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
